// File: hdl/cache_geom_pkg.sv
/*
 * Cache geometry
 * Field widths of the 16-bit byte address, the word size and the
 * sizes of the two-way cache and of the word-organised main memory
 */
`default_nettype none

package cache_geom_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// Tag, index and byte offset of a byte address
	localparam int TAG_W = 5;
	localparam int INDEX_W = 8;
	localparam int OFFSET_W = 3;

	localparam int WORDS_PER_BLOCK = 4;
	localparam int SETS = 256;       // Per way

	// One entry per 16-bit word of the address space
	localparam int MEM_WORDS = 32768;

endpackage

`default_nettype wire

// File: hdl/cache_ctrl_pkg.sv
/*
 * Cache controller types
 * Controller states, main memory opcodes and the read latency
 * of the pipelined memory
 */
`default_nettype none

package cache_ctrl_pkg;

	typedef enum logic [2:0] {
		ST_IDLE,        // Waiting for rd or wr
		ST_COMPARE,     // Tag check on the latched request
		ST_WRITEBACK,   // Dirty victim out to memory
		ST_FILL,        // Block in, critical word first
		ST_FINISH       // Merge of the write data
	} ctrl_state_t;

	typedef enum logic [1:0] {MEM_NONE, MEM_READ, MEM_WRITE} mem_op_t;

	localparam int MEM_LATENCY = 3;   // Cycles from read op to rvalid

endpackage

`default_nettype wire

// File: hdl/cache_way.sv
/*
 * Cache way
 * Tag, valid, dirty and data arrays of one way, read combinationally
 * by set index and word select, with the tag compare for a hit
 */
`default_nettype none

module cache_way (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [cache_geom_pkg::INDEX_W-1:0]  index,
	input  logic [cache_geom_pkg::OFFSET_W-2:0] word_sel,
	input  logic [cache_geom_pkg::TAG_W-1:0]    tag_in,
	input  logic                                wr_en,
	input  logic [cache_geom_pkg::DATA_W-1:0]   wr_data,
	input  logic                                fill,
	input  logic                                store,
	output logic                                hit,
	output logic                                valid,
	output logic                                dirty,
	output logic [cache_geom_pkg::TAG_W-1:0]    tag_out,
	output logic [cache_geom_pkg::DATA_W-1:0]   rd_data
);
	import cache_geom_pkg::*;

	logic [TAG_W-1:0]  tag_mem  [SETS];
	logic [DATA_W-1:0] data_mem [SETS*WORDS_PER_BLOCK];
	logic [SETS-1:0]   valid_q;
	logic [SETS-1:0]   dirty_q;

	assign valid = valid_q[index];
	assign dirty = dirty_q[index];
	assign tag_out = tag_mem[index];
	assign rd_data = data_mem[{index, word_sel}];
	assign hit = valid && (tag_out == tag_in);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_mem[index] <= tag_in;
			data_mem[{index, word_sel}] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (wr_en) begin
			if (fill) begin   // Word from memory
				valid_q[index] <= 1'b1;
				dirty_q[index] <= 1'b0;
			end
			if (store)
				dirty_q[index] <= 1'b1;
		end
	end

	// Controller never mixes a fill word with requester data
	assert property (@(posedge clk) disable iff (!rst_n) !(fill && store))
		else $error("cache_way: fill and store high together");

endmodule

`default_nettype wire

// File: hdl/way_select.sv
/*
 * Way selector
 * Picks the active way (the hitting way, else the victim by invalid
 * line first and then the per-set LRU bit), muxes its tag, dirty and
 * data, and steers the controller's write to it
 */
`default_nettype none

module way_select (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [cache_geom_pkg::INDEX_W-1:0] index,
	input  logic                               hit0,
	input  logic                               hit1,
	input  logic                               valid0,
	input  logic                               valid1,
	input  logic                               dirty0,
	input  logic                               dirty1,
	input  logic [cache_geom_pkg::TAG_W-1:0]   tag0,
	input  logic [cache_geom_pkg::TAG_W-1:0]   tag1,
	input  logic [cache_geom_pkg::DATA_W-1:0]  data0,
	input  logic [cache_geom_pkg::DATA_W-1:0]  data1,
	input  logic                               way_wr,
	input  logic                               lru_touch,
	output logic                               hit,
	output logic                               victim_dirty,
	output logic [cache_geom_pkg::TAG_W-1:0]   victim_tag,
	output logic [cache_geom_pkg::DATA_W-1:0]  sel_data,
	output logic                               way_wr0,
	output logic                               way_wr1
);
	import cache_geom_pkg::*;

	logic [SETS-1:0] lru;   // Names the way to evict
	logic victim;
	logic active;

	assign victim = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : lru[index]);
	assign hit = hit0 || hit1;
	assign active = hit ? hit1 : victim;

	assign victim_dirty = active ? dirty1 : dirty0;
	assign victim_tag = active ? tag1 : tag0;
	assign sel_data = active ? data1 : data0;
	assign way_wr0 = way_wr && !active;
	assign way_wr1 = way_wr && active;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			lru <= '0;
		else if (lru_touch)
			lru[index] <= !active;   // Point away from the way just used
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(hit0 && hit1))
		else $error("way_select: tag hit in both ways");

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
/*
 * Cache controller
 * Latches a request, checks the tag in the next cycle, and on a miss
 * writes back a dirty victim, then fills the block critical word first
 * with pipelined reads. A read miss completes on the critical word.
 */
`default_nettype none

module cache_ctrl (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [cache_geom_pkg::ADDR_W-1:0]   addr,
	input  logic [cache_geom_pkg::DATA_W-1:0]   data_in,
	input  logic                                rd,
	input  logic                                wr,
	input  logic                                hit,
	input  logic                                victim_dirty,
	input  logic [cache_geom_pkg::TAG_W-1:0]    victim_tag,
	input  logic [cache_geom_pkg::DATA_W-1:0]   sel_data,
	input  logic [cache_geom_pkg::DATA_W-1:0]   mem_rdata,
	input  logic                                mem_rvalid,
	output logic [cache_geom_pkg::DATA_W-1:0]   data_out,
	output logic                                done,
	output logic                                stall,
	output logic                                cache_hit,
	output logic                                err,
	output logic [cache_geom_pkg::INDEX_W-1:0]  index,
	output logic [cache_geom_pkg::OFFSET_W-2:0] word_sel,
	output logic [cache_geom_pkg::TAG_W-1:0]    tag_in,
	output logic [cache_geom_pkg::DATA_W-1:0]   wr_data,
	output logic                                fill,
	output logic                                store,
	output logic                                way_wr,
	output logic                                lru_touch,
	output cache_ctrl_pkg::mem_op_t             mem_op,
	output logic [cache_geom_pkg::ADDR_W-1:0]   mem_addr,
	output logic [cache_geom_pkg::DATA_W-1:0]   mem_wdata
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic [ADDR_W-1:0]   addr_q;
	logic [DATA_W-1:0]   data_q;
	logic                wr_q;
	logic [OFFSET_W-1:0] issue_cnt;   // Memory ops sent in this state
	logic [OFFSET_W-1:0] ret_cnt;     // Fill words returned
	logic [OFFSET_W-2:0] crit;
	logic                last_ret;

	assign tag_in = addr_q[ADDR_W-1 -: TAG_W];
	assign index = addr_q[OFFSET_W +: INDEX_W];
	assign crit = addr_q[OFFSET_W-1:1];
	assign last_ret = mem_rvalid && (ret_cnt == OFFSET_W'(WORDS_PER_BLOCK - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			addr_q <= '0;
			wr_q <= 1'b0;
			issue_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == ST_IDLE && (rd || wr)) begin
				addr_q <= addr;
				wr_q <= wr;
			end
			if (state_nxt != state) begin
				issue_cnt <= '0;
				ret_cnt <= '0;
			end else begin
				if (mem_op != MEM_NONE)
					issue_cnt <= issue_cnt + 1'b1;
				if (mem_rvalid)
					ret_cnt <= ret_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && wr)
			data_q <= data_in;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (rd || wr)
					state_nxt = ST_COMPARE;
			end
			ST_COMPARE: begin
				if (addr_q[0] || hit)
					state_nxt = ST_IDLE;
				else if (victim_dirty)
					state_nxt = ST_WRITEBACK;
				else
					state_nxt = ST_FILL;
			end
			ST_WRITEBACK: begin
				if (issue_cnt == OFFSET_W'(WORDS_PER_BLOCK - 1))
					state_nxt = ST_FILL;
			end
			ST_FILL: begin
				if (last_ret)
					state_nxt = wr_q ? ST_FINISH : ST_IDLE;
			end
			default: state_nxt = ST_IDLE;   // ST_FINISH
		endcase
	end

	always_comb begin
		done = 1'b0;
		cache_hit = 1'b0;
		err = 1'b0;
		stall = 1'b0;
		way_wr = 1'b0;
		fill = 1'b0;
		store = 1'b0;
		lru_touch = 1'b0;
		mem_op = MEM_NONE;
		word_sel = crit;
		wr_data = data_q;
		mem_addr = {tag_in, index, crit + issue_cnt[OFFSET_W-2:0], 1'b0};   // Wrapping order
		case (state)
			ST_COMPARE: begin
				if (addr_q[0]) begin   // Misaligned
					err = 1'b1;
					done = 1'b1;
				end else if (hit) begin
					done = 1'b1;
					cache_hit = 1'b1;
					lru_touch = 1'b1;
					way_wr = wr_q;
					store = wr_q;
				end else begin
					stall = 1'b1;
				end
			end
			ST_WRITEBACK: begin
				stall = 1'b1;
				mem_op = MEM_WRITE;
				word_sel = issue_cnt[OFFSET_W-2:0];
				mem_addr = {victim_tag, index, issue_cnt[OFFSET_W-2:0], 1'b0};
			end
			ST_FILL: begin
				stall = 1'b1;
				if (issue_cnt < OFFSET_W'(WORDS_PER_BLOCK))
					mem_op = MEM_READ;
				word_sel = crit + ret_cnt[OFFSET_W-2:0];
				wr_data = mem_rdata;
				way_wr = mem_rvalid;
				fill = mem_rvalid;
				// Critical word back, read completes early
				if (mem_rvalid && ret_cnt == '0 && !wr_q) begin
					done = 1'b1;
					lru_touch = 1'b1;
				end
			end
			ST_FINISH: begin
				done = 1'b1;
				lru_touch = 1'b1;
				way_wr = 1'b1;
				store = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign data_out = (state == ST_FILL) ? mem_rdata : sel_data;
	assign mem_wdata = sel_data;

	assert property (@(posedge clk) disable iff (!rst_n) state == ST_IDLE |-> mem_op == MEM_NONE)
		else $error("cache_ctrl: memory op issued while idle");
	assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("cache_ctrl: done high two cycles in a row");

endmodule

`default_nettype wire

// File: hdl/banked_mem.sv
/*
 * Main memory
 * Word memory behind a fixed-latency read pipeline, one op per cycle.
 * Every word holds its own word address after reset.
 */
`default_nettype none

module banked_mem (
	input  logic                              clk,
	input  logic                              rst_n,
	input  cache_ctrl_pkg::mem_op_t           mem_op,
	input  logic [cache_geom_pkg::ADDR_W-1:0] mem_addr,
	input  logic [cache_geom_pkg::DATA_W-1:0] mem_wdata,
	output logic [cache_geom_pkg::DATA_W-1:0] mem_rdata,
	output logic                              mem_rvalid
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	logic [DATA_W-1:0]      mem [MEM_WORDS];
	logic [DATA_W-1:0]      rdata_pipe [MEM_LATENCY];
	logic [MEM_LATENCY-1:0] rvalid_pipe;
	logic [ADDR_W-2:0]      word_addr;

	assign word_addr = mem_addr[ADDR_W-1:1];   // Byte bit dropped

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= DATA_W'(i);
			rvalid_pipe <= '0;
		end else begin
			if (mem_op == MEM_WRITE)
				mem[word_addr] <= mem_wdata;
			rvalid_pipe <= {rvalid_pipe[MEM_LATENCY-2:0], mem_op == MEM_READ};
		end
	end

	// Several reads in flight at once
	always_ff @(posedge clk) begin
		rdata_pipe[0] <= mem[word_addr];
		for (int s = 1; s < MEM_LATENCY; s++)
			rdata_pipe[s] <= rdata_pipe[s-1];
	end

	assign mem_rdata = rdata_pipe[MEM_LATENCY-1];
	assign mem_rvalid = rvalid_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

// File: hdl/mem_system.sv
/*
 * Memory system top
 * Two-way set-associative write-back cache with critical-word-first
 * fill in front of the pipelined main memory
 */
`default_nettype none

module mem_system (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [cache_geom_pkg::ADDR_W-1:0] addr,
	input  logic [cache_geom_pkg::DATA_W-1:0] data_in,
	input  logic                              rd,
	input  logic                              wr,
	output logic [cache_geom_pkg::DATA_W-1:0] data_out,
	output logic                              done,
	output logic                              stall,
	output logic                              cache_hit,
	output logic                              err
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	logic [INDEX_W-1:0]  index;
	logic [OFFSET_W-2:0] word_sel;
	logic [TAG_W-1:0]    tag_in;
	logic [DATA_W-1:0]   wr_data;
	logic                fill;
	logic                store;
	logic                way_wr;
	logic                lru_touch;
	logic                way_wr0;
	logic                way_wr1;
	logic                hit0;
	logic                hit1;
	logic                valid0;
	logic                valid1;
	logic                dirty0;
	logic                dirty1;
	logic [TAG_W-1:0]    tag0;
	logic [TAG_W-1:0]    tag1;
	logic [DATA_W-1:0]   data0;
	logic [DATA_W-1:0]   data1;
	logic                hit;
	logic                victim_dirty;
	logic [TAG_W-1:0]    victim_tag;
	logic [DATA_W-1:0]   sel_data;
	mem_op_t             mem_op;
	logic [ADDR_W-1:0]   mem_addr;
	logic [DATA_W-1:0]   mem_wdata;
	logic [DATA_W-1:0]   mem_rdata;
	logic                mem_rvalid;

	cache_way way0 (
		.clk, .rst_n, .index, .word_sel, .tag_in, .wr_en(way_wr0), .wr_data, .fill, .store,
		.hit(hit0), .valid(valid0), .dirty(dirty0), .tag_out(tag0), .rd_data(data0)
	);

	cache_way way1 (
		.clk, .rst_n, .index, .word_sel, .tag_in, .wr_en(way_wr1), .wr_data, .fill, .store,
		.hit(hit1), .valid(valid1), .dirty(dirty1), .tag_out(tag1), .rd_data(data1)
	);

	way_select sel (
		.clk, .rst_n, .index, .hit0, .hit1, .valid0, .valid1, .dirty0, .dirty1,
		.tag0, .tag1, .data0, .data1, .way_wr, .lru_touch,
		.hit, .victim_dirty, .victim_tag, .sel_data, .way_wr0, .way_wr1
	);

	cache_ctrl ctrl (.*);   // All ports match by name

	banked_mem mem (.*);

endmodule

`default_nettype wire

// File: testbench/clk_gen.sv
/*
 * Clock and reset source for the testbench
 * Free-running clock and an active-low reset held for two cycles
 */
`default_nettype none

module clk_gen (
	output logic clk,
	output logic rst_n
);
	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 2;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/tb_mem_system.sv
/*
 * Testbench for the cache memory system
 * Directed and random reads and writes, checked at each done against a
 * shadow memory and a two-way tag model with one LRU bit per set
 */
`default_nettype none

module tb_mem_system;
	import cache_geom_pkg::*;

	localparam int DONE_TIMEOUT = 200;
	localparam int STALL_TIMEOUT = 200;

	logic              clk;
	logic              rst_n;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data_in;
	logic              rd;
	logic              wr;
	logic [DATA_W-1:0] data_out;
	logic              done;
	logic              stall;
	logic              cache_hit;
	logic              err;

	// Reference state
	logic [DATA_W-1:0] shadow [MEM_WORDS];
	logic [TAG_W-1:0]  ref_tag0 [SETS];
	logic [TAG_W-1:0]  ref_tag1 [SETS];
	logic [SETS-1:0]   ref_valid0;
	logic [SETS-1:0]   ref_valid1;
	logic [SETS-1:0]   ref_lru;

	// Expected response of the access in flight
	logic              exp_rd;
	logic              exp_hit;
	logic              exp_err;
	logic              exp_stall;
	logic [DATA_W-1:0] exp_data;
	logic              pending;
	int                n_access;
	int                n_checked;

	clk_gen clocks (.clk, .rst_n);

	mem_system DUT (
		.clk, .rst_n, .addr, .data_in, .rd, .wr,
		.data_out, .done, .stall, .cache_hit, .err
	);

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int idx, input int word);
		return {TAG_W'(tag), INDEX_W'(idx), 2'(word), 1'b0};
	endfunction

	function automatic logic [DATA_W-1:0] shadow_word(input logic [ADDR_W-1:0] a);
		return shadow[a[ADDR_W-1:1]];
	endfunction

	function automatic logic predict_hit(input logic [ADDR_W-1:0] a);
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0]   tg;
		idx = a[OFFSET_W +: INDEX_W];
		tg = a[ADDR_W-1 -: TAG_W];
		return (ref_valid0[idx] && ref_tag0[idx] == tg) ||
			(ref_valid1[idx] && ref_tag1[idx] == tg);
	endfunction

	task automatic update_tags(input logic [ADDR_W-1:0] a);
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0]   tg;
		logic               way;
		idx = a[OFFSET_W +: INDEX_W];
		tg = a[ADDR_W-1 -: TAG_W];
		if (ref_valid0[idx] && ref_tag0[idx] == tg)
			way = 1'b0;
		else if (ref_valid1[idx] && ref_tag1[idx] == tg)
			way = 1'b1;
		else begin
			way = !ref_valid0[idx] ? 1'b0 : (!ref_valid1[idx] ? 1'b1 : ref_lru[idx]);
			if (way) begin
				ref_valid1[idx] = 1'b1;
				ref_tag1[idx] = tg;
			end else begin
				ref_valid0[idx] = 1'b1;
				ref_tag0[idx] = tg;
			end
		end
		ref_lru[idx] = !way;   // Evict the other way next
	endtask

	task automatic do_access(input logic [ADDR_W-1:0] a, input logic is_wr,
			input logic [DATA_W-1:0] wdata);
		int   wait_cnt;
		logic seen;
		@(posedge clk);
		exp_rd = !is_wr;
		exp_err = a[0];
		exp_hit = a[0] ? 1'b0 : predict_hit(a);
		exp_stall = !is_wr && !exp_hit && !exp_err;
		exp_data = shadow_word(a);
		if (!a[0]) begin
			update_tags(a);
			if (is_wr)
				shadow[a[ADDR_W-1:1]] = wdata;
		end
		pending = 1'b1;
		n_access++;
		addr <= a;
		data_in <= wdata;
		rd <= !is_wr;
		wr <= is_wr;
		wait_cnt = 0;
		seen = 1'b0;
		while (!seen && wait_cnt < DONE_TIMEOUT) begin
			@(negedge clk);
			wait_cnt++;
			seen = done;
		end
		if (!seen) begin
			$display("Timed out waiting for done on address 0x%h", a);
			abort_run();
		end else if ((exp_hit || exp_err) && wait_cnt != 2) begin
			$display("Hit or error on 0x%h not done one cycle after acceptance", a);
			abort_run();
		end
		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
		wait_cnt = 0;
		seen = 1'b0;
		while (!seen && wait_cnt < STALL_TIMEOUT) begin
			@(negedge clk);
			wait_cnt++;
			seen = !stall;
		end
		if (!seen) begin
			$display("Timed out waiting for stall to fall after address 0x%h", a);
			abort_run();
		end
	endtask

	task automatic read_word(input logic [ADDR_W-1:0] a);
		do_access(a, 1'b0, '0);
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		do_access(a, 1'b1, d);
	endtask

	// Compares every response at the falling edge
	always @(negedge clk) begin
		if (rst_n && done) begin
			if (!pending) begin
				$display("done pulsed with no request outstanding");
				abort_run();
			end else begin
				check_flag("err", err, exp_err);
				check_flag("cache_hit", cache_hit, exp_hit);
				check_flag("stall", stall, exp_stall);
				if (exp_rd && !exp_err)
					check_data("data_out", data_out, exp_data);
				pending = 1'b0;
				n_checked++;
			end
		end
	end

	initial begin
		int               wait_cnt;
		logic [ADDR_W-1:0] a;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		pending = 1'b0;
		n_access = 0;
		n_checked = 0;
		ref_valid0 = '0;
		ref_valid1 = '0;
		ref_lru = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			shadow[i] = DATA_W'(i);
		void'($urandom(94));
		wait_cnt = 0;
		while (!rst_n && wait_cnt < 20) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (!rst_n) begin
			$display("Reset was never released");
			abort_run();
		end

		// Untouched blocks come back as word addresses
		read_word(make_addr(0, 0, 0));
		read_word(make_addr(3, 8'h10, 2));
		read_word(make_addr(31, 8'hff, 3));

		write_word(make_addr(2, 8'h20, 1), 16'hbeef);
		read_word(make_addr(2, 8'h20, 1));
		read_word(make_addr(2, 8'h20, 3));

		// Third tag forces a dirty writeback
		write_word(make_addr(1, 8'h30, 2), 16'h1111);
		write_word(make_addr(2, 8'h30, 2), 16'h2222);
		write_word(make_addr(3, 8'h30, 2), 16'h3333);
		read_word(make_addr(1, 8'h30, 2));
		read_word(make_addr(2, 8'h30, 2));

		read_word(make_addr(4, 8'h40, 0));   // A
		read_word(make_addr(5, 8'h40, 1));   // B
		read_word(make_addr(4, 8'h40, 2));
		read_word(make_addr(6, 8'h40, 3));   // C evicts B
		read_word(make_addr(4, 8'h40, 1));
		read_word(make_addr(5, 8'h40, 1));

		// Misaligned accesses against a cached block
		a = make_addr(7, 8'h50, 1);
		read_word(a);
		read_word(a | 16'h1);
		write_word(a | 16'h1, 16'hdead);
		read_word(a);

		for (int n = 0; n < 300; n++) begin
			a = make_addr($urandom % 4, 8'h60 + $urandom % 2, $urandom % 4);
			if ($urandom % 2)
				write_word(a, DATA_W'($urandom));
			else
				read_word(a);
		end

		if (n_checked == n_access) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Only %0d of %0d accesses were checked", n_checked, n_access);
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: mem_system.f
hdl/cache_geom_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/cache_way.sv
hdl/way_select.sv
hdl/cache_ctrl.sv
hdl/banked_mem.sv
hdl/mem_system.sv
testbench/clk_gen.sv
testbench/tb_mem_system.sv
